// File: source/fir_pkg.sv
// Shared widths, settings addresses and readback codes for the FIR block
// Also holds the state type of the coefficient reload sequencer
`default_nettype none

package fir_pkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////

  // One I or Q part
  localparam int SAMPLE_W = 16;
  localparam int COEF_W   = 16;
  localparam int SHIFT_W  = 5;

  //////////////////////////////////////////////////
  // Settings bus
  //////////////////////////////////////////////////

  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int RB_DATA_W  = 64;
  localparam int RB_SEL_W   = 3;

  localparam logic [SET_ADDR_W-1:0] SR_COEF_LOAD = 8'd130;
  // Final coefficient word, commits the shadow bank
  localparam logic [SET_ADDR_W-1:0] SR_COEF_LAST = 8'd131;
  localparam logic [SET_ADDR_W-1:0] SR_SHIFT     = 8'd132;
  localparam logic [SET_ADDR_W-1:0] SR_READBACK  = 8'd255;

  // Readback select codes
  localparam logic [RB_SEL_W-1:0]  RB_NUM_TAPS = 3'd0;
  localparam logic [RB_SEL_W-1:0]  RB_RELOADS  = 3'd1;
  localparam logic [RB_DATA_W-1:0] RB_BAD_ADDR = 64'h0BADC0DE_0BADC0DE;

  // Reload sequencer states
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    COMMIT
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/axis_if.sv
// Stream bundle with data, last, valid and ready
// Master and slave views for the pipeline stages
`default_nettype none

interface axis_if #(
  parameter int DATA_W = 32
);

  logic [DATA_W-1:0] tdata;
  logic              tlast;
  logic              tvalid;
  logic              tready;

  modport master (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport slave (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

`default_nettype wire

// File: source/fir_ctrl.sv
// Settings registers, coefficient reload sequencer and readback mux
`default_nettype none

module fir_ctrl import fir_pkg::*; #(
  parameter int NUM_TAPS = 8
) (
  input  logic                  i_ce_clk,
  input  logic                  i_reset,
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  input  logic                  i_commit,
  output logic [RB_DATA_W-1:0]  o_rb_data,
  output logic [SHIFT_W-1:0]    o_shift,
  axis_if.master                reload
);

  localparam int RELOAD_CNT_W = 32;

  ctrl_state_t               state;
  ctrl_state_t               state_nxt;
  logic                      coef_wr;
  logic                      coef_accept;
  logic [COEF_W-1:0]         coef_q;
  logic [RB_SEL_W-1:0]       rb_sel;
  logic [RELOAD_CNT_W-1:0]   reload_cnt;

  //////////////////////////////////////////////////
  // Settings decode
  //////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      o_shift <= '0;
      rb_sel  <= RB_NUM_TAPS;
    end else if (i_set_stb) begin
      if (i_set_addr == SR_SHIFT) begin
        o_shift <= i_set_data[SHIFT_W-1:0];
      end
      if (i_set_addr == SR_READBACK) begin
        rb_sel <= i_set_data[RB_SEL_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Reload sequencer
  //////////////////////////////////////////////////

  assign coef_wr = i_set_stb &&
                   (i_set_addr == SR_COEF_LOAD || i_set_addr == SR_COEF_LAST);

  // A new word is taken once the previous one has gone out
  assign coef_accept = coef_wr && (state == IDLE || reload.tready);

  always_comb begin
    state_nxt = state;
    if (state != IDLE && reload.tready) begin
      state_nxt = IDLE;
    end
    if (coef_accept) begin
      state_nxt = (i_set_addr == SR_COEF_LAST) ? COMMIT : SEND;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (coef_accept) begin
      coef_q <= i_set_data[COEF_W-1:0];
    end
  end

  assign reload.tdata  = coef_q;
  assign reload.tvalid = (state != IDLE);
  assign reload.tlast  = (state == COMMIT);

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  // Completed reloads, as reported by the core
  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      reload_cnt <= '0;
    end else if (i_commit) begin
      reload_cnt <= reload_cnt + 1'b1;
    end
  end

  always_comb begin
    case (rb_sel)
      RB_NUM_TAPS: o_rb_data = RB_DATA_W'(NUM_TAPS);
      RB_RELOADS:  o_rb_data = RB_DATA_W'(reload_cnt);
      default:     o_rb_data = RB_BAD_ADDR;
    endcase
  end

endmodule

`default_nettype wire

// File: source/fir_mac_core.sv
// Delay line, shadow and active coefficient banks
// Pipelined multiply and sum for the I and Q parts
`default_nettype none

module fir_mac_core import fir_pkg::*; #(
  parameter int NUM_TAPS = 8,
  parameter int ACC_W    = 40
) (
  input  logic   i_ce_clk,
  input  logic   i_reset,
  axis_if.slave  in_s,
  axis_if.slave  reload_s,
  axis_if.master acc_s,
  output logic   o_commit
);

  localparam int PROD_W = SAMPLE_W + COEF_W;
  localparam int IDX_W  = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

  logic signed [COEF_W-1:0]   shadow_bank [NUM_TAPS];
  logic signed [COEF_W-1:0]   active_bank [NUM_TAPS];
  logic [IDX_W-1:0]           wr_idx;
  logic                       reload_fire;

  logic                       pipe_en;
  logic                       in_fire;
  logic                       dly_vld, prod_vld, sum_vld;
  logic                       dly_last, prod_last, sum_last;
  logic signed [SAMPLE_W-1:0] dly_i [NUM_TAPS];
  logic signed [SAMPLE_W-1:0] dly_q [NUM_TAPS];
  logic signed [PROD_W-1:0]   prod_i [NUM_TAPS];
  logic signed [PROD_W-1:0]   prod_q [NUM_TAPS];
  logic signed [ACC_W-1:0]    sum_i_nxt, sum_q_nxt;
  logic signed [ACC_W-1:0]    sum_i, sum_q;

  //////////////////////////////////////////////////
  // Coefficient banks
  //////////////////////////////////////////////////

  // Reload words are always taken in one cycle
  assign reload_s.tready = 1'b1;
  assign reload_fire     = reload_s.tvalid && reload_s.tready;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      wr_idx   <= '0;
      o_commit <= 1'b0;
      for (int k = 0; k < NUM_TAPS; k++) begin
        shadow_bank[k] <= '0;
        active_bank[k] <= '0;
      end
    end else begin
      o_commit <= reload_fire && reload_s.tlast;
      if (reload_fire) begin
        shadow_bank[wr_idx] <= reload_s.tdata;
        if (reload_s.tlast) begin
          wr_idx <= '0;
          // Last word joins the copy in the same cycle
          for (int k = 0; k < NUM_TAPS; k++) begin
            active_bank[k] <= (IDX_W'(k) == wr_idx) ? reload_s.tdata : shadow_bank[k];
          end
        end else if (wr_idx == IDX_W'(NUM_TAPS - 1)) begin
          wr_idx <= '0;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Pipeline control
  //////////////////////////////////////////////////

  // Whole pipeline holds while the sum stage is blocked
  assign pipe_en     = !(sum_vld && !acc_s.tready);
  assign in_s.tready = pipe_en;
  assign in_fire     = in_s.tvalid && pipe_en;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      dly_vld  <= 1'b0;
      prod_vld <= 1'b0;
      sum_vld  <= 1'b0;
    end else if (pipe_en) begin
      dly_vld  <= in_s.tvalid;
      prod_vld <= dly_vld;
      sum_vld  <= prod_vld;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (pipe_en) begin
      dly_last  <= in_s.tlast;
      prod_last <= dly_last;
      sum_last  <= prod_last;
    end
  end

  //////////////////////////////////////////////////
  // Delay line, products and sums
  //////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        dly_i[k] <= '0;
        dly_q[k] <= '0;
      end
    end else if (in_fire) begin
      dly_i[0] <= in_s.tdata[2*SAMPLE_W-1:SAMPLE_W];
      dly_q[0] <= in_s.tdata[SAMPLE_W-1:0];
      for (int k = 1; k < NUM_TAPS; k++) begin
        dly_i[k] <= dly_i[k-1];
        dly_q[k] <= dly_q[k-1];
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (pipe_en) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        prod_i[k] <= dly_i[k] * active_bank[k];
        prod_q[k] <= dly_q[k] * active_bank[k];
      end
    end
  end

  // Sign-extended adder tree
  always_comb begin
    sum_i_nxt = '0;
    sum_q_nxt = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      sum_i_nxt = sum_i_nxt + ACC_W'(prod_i[k]);
      sum_q_nxt = sum_q_nxt + ACC_W'(prod_q[k]);
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (pipe_en) begin
      sum_i <= sum_i_nxt;
      sum_q <= sum_q_nxt;
    end
  end

  assign acc_s.tdata  = {sum_i, sum_q};
  assign acc_s.tlast  = sum_last;
  assign acc_s.tvalid = sum_vld;

endmodule

`default_nettype wire

// File: source/fir_round_clip.sv
// Rounding shift and 16-bit saturation for the I and Q accumulators
`default_nettype none

module fir_round_clip import fir_pkg::*; #(
  parameter int ACC_W = 40
) (
  input  logic                  i_ce_clk,
  input  logic                  i_reset,
  input  logic [SHIFT_W-1:0]    i_shift,
  axis_if.slave                 acc_s,
  output logic [2*SAMPLE_W-1:0] o_tdata,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  i_ready
);

  localparam logic signed [ACC_W:0] SAT_MAX = (ACC_W+1)'(2**(SAMPLE_W-1) - 1);
  localparam logic signed [ACC_W:0] SAT_MIN = -(ACC_W+1)'(2**(SAMPLE_W-1));

  logic stage_en;

  // Round half up, shift right, then clip to the sample range
  function automatic logic [SAMPLE_W-1:0] round_clip(
    input logic signed [ACC_W-1:0] acc,
    input logic [SHIFT_W-1:0]      sh
  );
    logic signed [ACC_W:0] biased;
    logic signed [ACC_W:0] shifted;
    biased = {acc[ACC_W-1], acc};
    if (sh != '0) begin
      biased = biased + ((ACC_W+1)'(1) <<< (sh - 1'b1));
    end
    shifted = biased >>> sh;
    if (shifted > SAT_MAX) begin
      return SAT_MAX[SAMPLE_W-1:0];
    end else if (shifted < SAT_MIN) begin
      return SAT_MIN[SAMPLE_W-1:0];
    end
    return shifted[SAMPLE_W-1:0];
  endfunction

  // Held while the output word waits
  assign stage_en     = !(o_tvalid && !i_ready);
  assign acc_s.tready = stage_en;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      o_tvalid <= 1'b0;
    end else if (stage_en) begin
      o_tvalid <= acc_s.tvalid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (stage_en && acc_s.tvalid) begin
      o_tdata <= {round_clip(acc_s.tdata[2*ACC_W-1:ACC_W], i_shift),
                  round_clip(acc_s.tdata[ACC_W-1:0], i_shift)};
      o_tlast <= acc_s.tlast;
    end
  end

endmodule

`default_nettype wire

// File: source/fir_filter_block.sv
// Top level of the complex FIR block
// Joins the settings control, MAC core and round/clip stage
`default_nettype none

module fir_filter_block import fir_pkg::*; #(
  parameter int NUM_TAPS = 8,
  parameter int ACC_W    = 40
) (
  input  logic                  i_ce_clk,
  input  logic                  i_reset,
  // Settings bus
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  output logic [RB_DATA_W-1:0]  o_rb_data,
  // Sample input stream
  input  logic [2*SAMPLE_W-1:0] i_tdata,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  i_tready,
  // Filtered output stream
  output logic [2*SAMPLE_W-1:0] o_tdata,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  o_tready
);

  logic [SHIFT_W-1:0] shift;
  logic               commit;

  axis_if #(.DATA_W(2*SAMPLE_W)) in_s ();
  axis_if #(.DATA_W(2*ACC_W))    acc_s ();
  axis_if #(.DATA_W(COEF_W))     reload_s ();

  assign in_s.tdata  = i_tdata;
  assign in_s.tlast  = i_tlast;
  assign in_s.tvalid = i_tvalid;
  assign i_tready    = in_s.tready;

  //////////////////////////////////////////////////
  // Control and datapath
  //////////////////////////////////////////////////

  fir_ctrl #(
    .NUM_TAPS(NUM_TAPS)
  ) u_ctrl (
    .i_ce_clk  (i_ce_clk),
    .i_reset   (i_reset),
    .i_set_stb (i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .i_commit  (commit),
    .o_rb_data (o_rb_data),
    .o_shift   (shift),
    .reload    (reload_s.master)
  );

  fir_mac_core #(
    .NUM_TAPS(NUM_TAPS),
    .ACC_W   (ACC_W)
  ) u_mac_core (
    .i_ce_clk(i_ce_clk),
    .i_reset (i_reset),
    .in_s    (in_s.slave),
    .reload_s(reload_s.slave),
    .acc_s   (acc_s.master),
    .o_commit(commit)
  );

  fir_round_clip #(
    .ACC_W(ACC_W)
  ) u_round_clip (
    .i_ce_clk(i_ce_clk),
    .i_reset (i_reset),
    .i_shift (shift),
    .acc_s   (acc_s.slave),
    .o_tdata (o_tdata),
    .o_tlast (o_tlast),
    .o_tvalid(o_tvalid),
    .i_ready (o_tready)
  );

endmodule

`default_nettype wire

// File: verification/fir_tb.sv
// Testbench for the complex FIR filter block
// Clock and reset, settings and stream drivers, reference model, checks and watchdog
`default_nettype none

module fir_tb import fir_pkg::*; ();

  localparam int NUM_TAPS       = 8;
  localparam int ACC_W          = 40;
  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 4;
  // Words held when delay, product, sum and output stages are all full
  localparam int PIPE_DEPTH     = 4;
  // Stream words sent over all tests
  localparam int TEST_WORDS     = 92;
  localparam int TIMEOUT_CYCLES = TEST_WORDS * 20;

  logic                  clk;
  logic                  reset;
  logic                  set_stb;
  logic [SET_ADDR_W-1:0] set_addr;
  logic [SET_DATA_W-1:0] set_data;
  logic [RB_DATA_W-1:0]  rb_data;
  logic [2*SAMPLE_W-1:0] in_tdata;
  logic                  in_tlast;
  logic                  in_tvalid;
  logic                  in_tready;
  logic [2*SAMPLE_W-1:0] out_tdata;
  logic                  out_tlast;
  logic                  out_tvalid;
  logic                  out_tready;
  logic                  rand_ready;

  integer seed = 32'heae3f185;

  // Reference model state
  int          coef_m   [NUM_TAPS];
  int          shadow_m [NUM_TAPS];
  int          hist_i   [NUM_TAPS] = '{default: 0};
  int          hist_q   [NUM_TAPS] = '{default: 0};
  int          shadow_idx;
  int          shift_m;
  int          reloads_m;
  logic [32:0] stim_q [$];
  logic [32:0] exp_q [$];
  logic [32:0] exp_word;
  logic        hold_prev = 1'b0;
  logic [32:0] held_word;

  int mon_errors    = 0;
  int words_checked = 0;
  int seq_errors;
  int tests_run;
  int tests_failed;
  int errs_at_start;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Output ready, either held high or randomly dropped
  initial begin
    out_tready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_tready = rand_ready ? (({$random(seed)} % 4) != 0) : 1'b1;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  fir_filter_block #(
    .NUM_TAPS(NUM_TAPS),
    .ACC_W   (ACC_W)
  ) dut0 (
    .i_ce_clk  (clk),
    .i_reset   (reset),
    .i_set_stb (set_stb),
    .i_set_addr(set_addr),
    .i_set_data(set_data),
    .o_rb_data (rb_data),
    .i_tdata   (in_tdata),
    .i_tlast   (in_tlast),
    .i_tvalid  (in_tvalid),
    .i_tready  (in_tready),
    .o_tdata   (out_tdata),
    .o_tlast   (out_tlast),
    .o_tvalid  (out_tvalid),
    .o_tready  (out_tready)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Round half up, arithmetic shift, clip to 16 bits
  function automatic logic [15:0] expected_part(input longint acc, input int sh);
    longint v;
    v = acc;
    if (sh > 0) begin
      v = v + (longint'(1) << (sh - 1));
    end
    v = v >>> sh;
    if (v > 64'sd32767) begin
      v = 64'sd32767;
    end else if (v < -64'sd32768) begin
      v = -64'sd32768;
    end
    return v[15:0];
  endfunction

  function automatic logic [32:0] model_step(input logic [31:0] data, input logic last);
    longint acc_i;
    longint acc_q;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      hist_i[k] = hist_i[k-1];
      hist_q[k] = hist_q[k-1];
    end
    hist_i[0] = int'($signed(data[31:16]));
    hist_q[0] = int'($signed(data[15:0]));
    acc_i = 0;
    acc_q = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc_i += longint'(hist_i[k]) * longint'(coef_m[k]);
      acc_q += longint'(hist_q[k]) * longint'(coef_m[k]);
    end
    return {last, expected_part(acc_i, shift_m), expected_part(acc_q, shift_m)};
  endfunction

  // Stream monitor and scoreboard
  always @(posedge clk) begin
    if (!reset) begin
      if (hold_prev) begin
        assert (out_tvalid && {out_tlast, out_tdata} == held_word) else begin
          $display("[ERROR] %0t output word changed while stalled", $time);
          mon_errors++;
        end
      end
      assert (exp_q.size() <= PIPE_DEPTH) else begin
        $display("[ERROR] %0t %0d words inside the pipeline", $time, exp_q.size());
        mon_errors++;
      end
      if (out_tvalid && !out_tready && exp_q.size() == PIPE_DEPTH) begin
        assert (!in_tready) else begin
          $display("[ERROR] %0t input ready high while the full pipeline is stalled", $time);
          mon_errors++;
        end
      end
      if (out_tvalid && out_tready) begin
        if (exp_q.size() == 0) begin
          $display("Output word at time %0t arrived with no input word pending", $time);
          mon_errors++;
        end else begin
          exp_word = exp_q.pop_front();
          assert ({out_tlast, out_tdata} == exp_word) else begin
            $display("[ERROR] %0t word %0d got I=%0d Q=%0d last=%0b, expected I=%0d Q=%0d last=%0b",
                     $time, words_checked, $signed(out_tdata[31:16]), $signed(out_tdata[15:0]),
                     out_tlast, $signed(exp_word[31:16]), $signed(exp_word[15:0]), exp_word[32]);
            mon_errors++;
          end
          words_checked++;
        end
      end
      if (in_tvalid && in_tready) begin
        exp_q.push_back(model_step(in_tdata, in_tlast));
      end
      hold_prev = out_tvalid && !out_tready;
      held_word = {out_tlast, out_tdata};
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic write_setting(input logic [SET_ADDR_W-1:0] addr,
                               input logic [SET_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(posedge clk);
    #1;
    set_stb = 1'b0;
    if (addr == SR_COEF_LOAD || addr == SR_COEF_LAST) begin
      shadow_m[shadow_idx] = int'($signed(data[15:0]));
      if (addr == SR_COEF_LAST) begin
        coef_m     = shadow_m;
        shadow_idx = 0;
        reloads_m++;
      end else begin
        shadow_idx = (shadow_idx + 1) % NUM_TAPS;
      end
    end else if (addr == SR_SHIFT) begin
      shift_m = int'(data[SHIFT_W-1:0]);
    end
  endtask

  task automatic load_coefs(input int c [NUM_TAPS]);
    for (int k = 0; k < NUM_TAPS - 1; k++) begin
      write_setting(SR_COEF_LOAD, 32'(c[k]));
    end
    write_setting(SR_COEF_LAST, 32'(c[NUM_TAPS-1]));
  endtask

  task automatic check_readback(input logic [RB_SEL_W-1:0] sel,
                                input logic [RB_DATA_W-1:0] expected);
    write_setting(SR_READBACK, 32'(sel));
    assert (rb_data == expected) else begin
      $display("[ERROR] %0t readback select %0d gave %h, expected %h",
               $time, sel, rb_data, expected);
      seq_errors++;
    end
  endtask

  function automatic int random_signed(input int bits);
    int r;
    r = $random(seed);
    return (r <<< (32 - bits)) >>> (32 - bits);
  endfunction

  function automatic void queue_sample(input int i_val, input int q_val, input logic last);
    stim_q.push_back({last, 16'(i_val), 16'(q_val)});
  endfunction

  task automatic send_stim(input logic gaps);
    logic [32:0] w;
    int          idle;
    while (stim_q.size() != 0) begin
      w = stim_q.pop_front();
      idle = gaps ? ({$random(seed)} % 3) : 0;
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      in_tvalid = 1'b1;
      in_tdata  = w[31:0];
      in_tlast  = w[32];
      @(posedge clk);
      while (!in_tready) @(posedge clk);
      #1;
      in_tvalid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  task automatic start_test();
    errs_at_start = mon_errors + seq_errors;
  endtask

  task automatic finish_test(input int num, input string name);
    int errs;
    errs = mon_errors + seq_errors - errs_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int coefs [NUM_TAPS];
    reset      = 1'b1;
    set_stb    = 1'b0;
    set_addr   = '0;
    set_data   = '0;
    in_tdata   = '0;
    in_tlast   = 1'b0;
    in_tvalid  = 1'b0;
    rand_ready = 1'b0;
    seq_errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    shadow_idx   = 0;
    shift_m      = 0;
    reloads_m    = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      coef_m[k]   = 0;
      shadow_m[k] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test();
    assert (!out_tvalid) else begin
      $display("[ERROR] %0t output valid high after reset", $time);
      seq_errors++;
    end
    check_readback(RB_NUM_TAPS, 64'(NUM_TAPS));
    check_readback(RB_RELOADS, 64'd0);
    check_readback(3'd5, 64'h0BADC0DE_0BADC0DE);
    finish_test(1, "reset state and readback");

    start_test();
    for (int k = 0; k < NUM_TAPS; k++) begin
      coefs[k] = k + 1;
    end
    write_setting(SR_SHIFT, 32'd0);
    load_coefs(coefs);
    queue_sample(100, -100, 1'b0);
    for (int k = 1; k < NUM_TAPS; k++) begin
      queue_sample(0, 0, k == NUM_TAPS - 1);
    end
    send_stim(1'b0);
    wait_drain();
    finish_test(2, "impulse response");

    start_test();
    for (int k = 0; k < NUM_TAPS; k++) begin
      coefs[k] = random_signed(4);
    end
    write_setting(SR_SHIFT, 32'd4);
    load_coefs(coefs);
    for (int n = 0; n < 20; n++) begin
      queue_sample(random_signed(12), random_signed(12), (n % 5) == 4);
    end
    send_stim(1'b0);
    wait_drain();
    check_readback(RB_RELOADS, 64'(reloads_m));
    finish_test(3, "random samples with rounding");

    // Full-scale input against extreme taps
    start_test();
    for (int k = 0; k < NUM_TAPS; k++) begin
      coefs[k] = (k % 2 == 0) ? 32767 : -32768;
    end
    write_setting(SR_SHIFT, 32'd0);
    load_coefs(coefs);
    for (int n = 0; n < 8; n++) begin
      queue_sample((n % 2 == 0) ? 32767 : -32768, (n % 2 == 0) ? -32768 : 32767, n == 7);
    end
    send_stim(1'b0);
    wait_drain();
    finish_test(4, "saturation");

    start_test();
    for (int k = 0; k < NUM_TAPS; k++) begin
      coefs[k] = random_signed(10);
    end
    write_setting(SR_SHIFT, 32'd6);
    load_coefs(coefs);
    rand_ready = 1'b1;
    // Back-to-back burst fills every stage while the output stalls
    for (int n = 0; n < 20; n++) begin
      queue_sample(random_signed(16), random_signed(16), ({$random(seed)} % 4) == 0);
    end
    send_stim(1'b0);
    for (int n = 0; n < 20; n++) begin
      queue_sample(random_signed(16), random_signed(16), ({$random(seed)} % 4) == 0);
    end
    send_stim(1'b1);
    wait_drain();
    rand_ready = 1'b0;
    finish_test(5, "back-pressure and gaps");

    // Partial reload stays in the shadow bank until the last word
    start_test();
    for (int k = 0; k < NUM_TAPS - 1; k++) begin
      write_setting(SR_COEF_LOAD, 32'(random_signed(8)));
    end
    for (int n = 0; n < 8; n++) begin
      queue_sample(random_signed(12), random_signed(12), n == 7);
    end
    send_stim(1'b0);
    wait_drain();
    write_setting(SR_COEF_LAST, 32'(random_signed(8)));
    for (int n = 0; n < 8; n++) begin
      queue_sample(random_signed(12), random_signed(12), n == 7);
    end
    send_stim(1'b0);
    wait_drain();
    check_readback(RB_RELOADS, 64'(reloads_m));
    finish_test(6, "coefficient commit");

    $display("Tests run %0d, failed %0d, words checked %0d, errors %0d",
             tests_run, tests_failed, words_checked, mon_errors + seq_errors);
    if (tests_failed == 0 && mon_errors + seq_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/fir_pkg.sv
source/axis_if.sv
source/fir_ctrl.sv
source/fir_mac_core.sv
source/fir_round_clip.sv
source/fir_filter_block.sv
verification/fir_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := fir_tb
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
